// ==== src/cycPkg.sv ====
// Bus-cycle timing definitions
// One-hot T-state and machine-cycle encodings
// T-state counts of an opcode fetch and a memory read

`default_nettype none

package cycPkg;

  // One-hot T-states, T2 is the one that stretches on wait
  typedef enum logic [3:0] {
    T1 = 4'b0001,
    T2 = 4'b0010,
    T3 = 4'b0100,
    T4 = 4'b1000
  } tState_e;

  // One-hot machine cycles
  typedef enum logic [2:0] {
    M1 = 3'b001,  // Opcode fetch
    M2 = 3'b010,  // Operand low byte
    M3 = 3'b100   // Operand high byte
  } mCycle_e;

  localparam int FetchTStates = 4;
  localparam int ReadTStates  = 3;

endpackage

`default_nettype wire

// ==== src/isaPkg.sv ====
// Instruction-set definitions
// Opcodes kept by the decoder, interrupt vectors, refresh counter width

`default_nettype none

package isaPkg;

  typedef enum logic [7:0] {
    OpNop  = 8'h00,
    OpHalt = 8'h76,
    OpDi   = 8'hF3,
    OpEi   = 8'hFB,
    OpJp   = 8'hC3   // JP nn
  } opcode_e;

  // ------------------------------
  // Vectors
  localparam logic [15:0] NmiVector = 16'h0066;
  localparam logic [15:0] IntVector = 16'h0038;   // Interrupt mode 1

  // Low bits of R that count, bit 7 stays put
  localparam int RefreshBits = 7;

endpackage

`default_nettype wire

// ==== src/tvDecode.sv ====
// Instruction decoder for NOP, HALT, DI, EI and JP nn
// Gives the last machine cycle and the per-cycle controls

`timescale 1ns/1ps
`default_nettype none

module tvDecode
  import cycPkg::*;
  import isaPkg::*;
(
  input  opcode_e ir,
  input  mCycle_e mCycle,
  output logic    lastM,
  output logic    isJump,
  output logic    isHalt,
  output logic    setEi,
  output logic    setDi,
  output logic    loadTmpLo,
  output logic    loadTmpHi
);

  always_comb
  begin
    lastM     = (mCycle == M1);  // Single-cycle by default
    isJump    = 1'b0;
    isHalt    = 1'b0;
    setEi     = 1'b0;
    setDi     = 1'b0;
    loadTmpLo = 1'b0;
    loadTmpHi = 1'b0;
    case (ir)
      OpHalt:
        isHalt = 1'b1;
      OpDi:
        setDi = 1'b1;
      OpEi:
        setEi = 1'b1;
      OpJp:
      begin
        lastM     = (mCycle == M3);
        isJump    = 1'b1;
        loadTmpLo = (mCycle == M2);
        loadTmpHi = (mCycle == M3);
      end
      default: ;  // NOP and anything unknown
    endcase
  end

endmodule

`default_nettype wire

// ==== src/tvIntCtrl.sv ====
// Interrupt and bus-request control
// Input synchronisers and NMI falling-edge latch
// IFF1/IFF2, interrupt acceptance, halt state and bus grant

`timescale 1ns/1ps
`default_nettype none

module tvIntCtrl
(
  input  logic clk,
  input  logic reset_n,
  input  logic int_n,
  input  logic nmi_n,
  input  logic busrq_n,
  input  logic tRes,
  input  logic lastM,
  input  logic isHalt,
  input  logic setEi,
  input  logic setDi,
  input  logic fetchDone,
  output logic nmiCycle,
  output logic intCycle,
  output logic holdBus,
  output logic halted,
  output logic iff1
);

  logic busReqS;
  logic intS;
  logic nmiS;
  logic nmiOld;
  logic nmiPend;
  logic iff2;
  logic instEnd;
  logic takeNmi;
  logic takeInt;

  assign instEnd = tRes & lastM;
  assign takeNmi = instEnd & nmiPend;
  // No INT right after EI, nor on the DI that masks it
  assign takeInt = instEnd & ~nmiPend & iff1 & intS & ~setEi & ~setDi;

  // ------------------------------
  // Synchronisers
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      busReqS <= 1'b0;
      intS    <= 1'b0;
      nmiS    <= 1'b1;
      nmiOld  <= 1'b1;
      nmiPend <= 1'b0;
    end
    else
    begin
      busReqS <= ~busrq_n;
      intS    <= ~int_n;
      nmiS    <= nmi_n;
      nmiOld  <= nmiS;
      if (nmiCycle && fetchDone)
        nmiPend <= 1'b0;         // Served once the replaced fetch is under way
      else if (nmiOld && !nmiS)
        nmiPend <= 1'b1;         // Falling edge
    end
  end

  // ------------------------------
  // Acceptance, IFFs, halt, grant
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      nmiCycle <= 1'b0;
      intCycle <= 1'b0;
      holdBus  <= 1'b0;
      halted   <= 1'b0;
      iff1     <= 1'b0;
      iff2     <= 1'b0;
    end
    else if (holdBus)
    begin
      if (!busReqS)
        holdBus <= 1'b0;
    end
    else if (tRes)
    begin
      holdBus <= busReqS;        // Grant only between cycles
      if (lastM)
      begin
        nmiCycle <= takeNmi;
        intCycle <= takeInt;
      end
      if (lastM && isHalt)
        halted <= 1'b1;
      if (lastM && setEi)
      begin
        iff1 <= 1'b1;
        iff2 <= 1'b1;
      end
      if (lastM && setDi)
      begin
        iff1 <= 1'b0;
        iff2 <= 1'b0;
      end
      if (takeNmi)
      begin
        iff1   <= 1'b0;          // IFF2 keeps the state to restore
        halted <= 1'b0;
      end
      if (takeInt)
      begin
        iff1   <= 1'b0;
        iff2   <= 1'b0;
        halted <= 1'b0;
      end
    end
  end

  a_oneCycleKind: assert property (@(posedge clk) disable iff (!reset_n)
    !(nmiCycle && intCycle));
  a_grantAtEnd: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(holdBus) |-> $past(tRes));

endmodule

`default_nettype wire

// ==== src/tvSequencer.sv ====
// T-state and machine-cycle sequencer
// One-hot T1..T4 rotation with wait stretching in T2
// Machine-cycle stepping, m1_n and rfsh_n strobes

`timescale 1ns/1ps
`default_nettype none

module tvSequencer
  import cycPkg::*;
(
  input  logic    clk,
  input  logic    reset_n,
  input  logic    wait_n,
  input  logic    lastM,       // Current cycle ends the instruction
  input  logic    holdBus,     // Bus granted, everything frozen at T1
  output tState_e tState,
  output mCycle_e mCycle,
  output logic    tRes,
  output logic    fetchDone,
  output logic    m1_n,
  output logic    rfsh_n
);

  logic lastT;
  logic stretch;
  logic m1Q;

  // Opcode fetch ends in T4, memory reads in T3
  assign lastT     = (mCycle == M1) ? tState[FetchTStates-1] : tState[ReadTStates-1];
  assign tRes      = lastT & ~holdBus;
  assign stretch   = (tState == T2) & ~wait_n;
  assign fetchDone = (mCycle == M1) & (tState == T2) & wait_n;

  // M1 stays inactive while the bus is handed out
  assign m1_n = m1Q | holdBus;

  // ------------------------------
  // State machine
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      tState <= T4;              // End of an M1, first clock opens a fetch
      mCycle <= M1;
      m1Q    <= 1'b1;
      rfsh_n <= 1'b1;
    end
    else if (!holdBus)
    begin
      if (tRes)
      begin
        tState <= T1;
        rfsh_n <= 1'b1;
        if (lastM)
        begin
          mCycle <= M1;
          m1Q    <= 1'b0;        // Next fetch starts
        end
        else
        begin
          mCycle <= mCycle_e'({mCycle[1:0], mCycle[2]});
        end
      end
      else if (!stretch)
      begin
        tState <= tState_e'({tState[2:0], tState[3]});
        if (fetchDone)
        begin
          m1Q    <= 1'b1;
          rfsh_n <= 1'b0;        // Refresh for T3 and T4
        end
      end
    end
  end

  a_tStateOneHot: assert property (@(posedge clk) disable iff (!reset_n)
    $onehot(tState));

endmodule

`default_nettype wire

// ==== src/tvAddrUnit.sv ====
// Address unit
// PC, temporary address register, IR and refresh counter R
// Address bus register with fetch, operand, refresh, jump and vector sources

`timescale 1ns/1ps
`default_nettype none

module tvAddrUnit
  import cycPkg::*;
  import isaPkg::*;
#(
  parameter int AddrWidth = 16
)
(
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic [7:0]           dinst,
  input  logic [7:0]           di,
  input  logic                 tRes,
  input  logic                 fetchDone,
  input  logic                 loadTmpLo,
  input  logic                 loadTmpHi,
  input  logic                 isJump,
  input  logic                 lastM,
  input  logic                 nmiCycle,
  input  logic                 intCycle,
  input  logic                 halted,
  input  tState_e              tState,
  input  mCycle_e              mCycle,
  output opcode_e              ir,
  output logic [AddrWidth-1:0] A
);

  logic [AddrWidth-1:0]   pc;
  logic [AddrWidth-1:0]   pcSeq;
  logic [AddrWidth-1:0]   nextA;
  logic [15:0]            tmpAddr;
  logic [15:0]            tmpNext;
  logic [RefreshBits-1:0] r;
  logic                   replaced;

  assign replaced = nmiCycle | intCycle;   // Fetch taken over by an interrupt
  // Operand reads step the PC here, the fetch already stepped it
  assign pcSeq = (mCycle == M1) ? pc : pc + 1'b1;

  // Operand bytes arrive in T3 of their read
  always_comb
  begin
    tmpNext = tmpAddr;
    if (tState == T3 && loadTmpLo)
      tmpNext[7:0] = di;
    if (tState == T3 && loadTmpHi)
      tmpNext[15:8] = di;
  end

  // Address of the cycle that follows this tRes
  always_comb
  begin
    nextA = pcSeq;
    if (lastM && isJump)
      nextA = tmpNext[AddrWidth-1:0];
    else if (lastM && nmiCycle)
      nextA = NmiVector[AddrWidth-1:0];
    else if (lastM && intCycle)
      nextA = IntVector[AddrWidth-1:0];
  end

  always_ff @(posedge clk)
  begin
    tmpAddr <= tmpNext;
  end

  // ------------------------------
  // PC, IR, R and address bus
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      pc <= '0;
      A  <= '0;
      ir <= OpNop;
      r  <= '0;
    end
    else if (fetchDone)
    begin
      ir <= (replaced || halted) ? OpNop : opcode_e'(dinst);
      if (!(replaced || halted))
        pc <= pc + 1'b1;
      A <= AddrWidth'(r);        // {I,R} with I held at zero
      r <= r + 1'b1;
    end
    else if (tRes)
    begin
      pc <= nextA;
      A  <= nextA;
    end
  end

endmodule

`default_nettype wire

// ==== src/tvCore.sv ====
// Top level of the reduced TV80 bus-cycle core
// Decoder, interrupt control, sequencer and address unit
// Active-low status outputs

`timescale 1ns/1ps
`default_nettype none

module tvCore
  import cycPkg::*;
  import isaPkg::*;
#(
  parameter int AddrWidth = 16
)
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        wait_n,
  input  logic        int_n,
  input  logic        nmi_n,
  input  logic        busrq_n,
  input  logic [7:0]  dinst,
  input  logic [7:0]  di,
  output logic [15:0] A,
  output logic        m1_n,
  output logic        rfsh_n,
  output logic        halt_n,
  output logic        busak_n,
  output logic        intcycle_n,
  output logic        IntE
);

  opcode_e              ir;
  tState_e              tState;
  mCycle_e              mCycle;
  logic                 lastM;
  logic                 isJump;
  logic                 isHalt;
  logic                 setEi;
  logic                 setDi;
  logic                 loadTmpLo;
  logic                 loadTmpHi;
  logic                 tRes;
  logic                 fetchDone;
  logic                 nmiCycle;
  logic                 intCycle;
  logic                 holdBus;
  logic                 halted;
  logic                 iff1;
  logic [AddrWidth-1:0] aBus;

  tvDecode u_decode
  (
    .ir, .mCycle, .lastM, .isJump, .isHalt, .setEi, .setDi, .loadTmpLo, .loadTmpHi
  );

  tvIntCtrl u_intCtrl
  (
    .clk, .reset_n, .int_n, .nmi_n, .busrq_n, .tRes, .lastM, .isHalt, .setEi, .setDi,
    .fetchDone, .nmiCycle, .intCycle, .holdBus, .halted, .iff1
  );

  tvSequencer u_sequencer
  (
    .clk, .reset_n, .wait_n, .lastM, .holdBus, .tState, .mCycle, .tRes, .fetchDone,
    .m1_n, .rfsh_n
  );

  tvAddrUnit #(.AddrWidth(AddrWidth)) u_addrUnit
  (
    .clk, .reset_n, .dinst, .di, .tRes, .fetchDone, .loadTmpLo, .loadTmpHi, .isJump,
    .lastM, .nmiCycle, .intCycle, .halted, .tState, .mCycle, .ir,
    .A (aBus)
  );

  assign A          = 16'(aBus);   // Zero-extended for narrow builds
  assign halt_n     = ~halted;
  assign busak_n    = ~holdBus;
  assign intcycle_n = ~intCycle;
  assign IntE       = iff1;

endmodule

`default_nettype wire

// ==== test/tvClkGen.sv ====
// Testbench clock and reset source
// 40 ns clock, reset_n held low for the first 8 rising edges

`timescale 1ns/1ps
`default_nettype none

module tvClkGen
#(
  parameter int HalfPeriod  = 20,
  parameter int ResetCycles = 8
)
(
  output logic clk,
  output logic reset_n
);

  initial
  begin
    clk = 1'b0;
    forever #(HalfPeriod) clk = ~clk;
  end

  initial
  begin
    reset_n = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    reset_n <= 1'b1;            // Released on a rising edge
  end

endmodule

`default_nettype wire

// ==== test/tvCoreTb.sv ====
// Testbench for the reduced TV80 bus-cycle core
// Memory model, random wait states, fetch-address reference model
// Reset, JP/NOP flow, refresh, HALT with NMI, IM1 interrupt and bus grant

`timescale 1ns/1ps
`default_nettype none

module tvCoreTb
  import cycPkg::*;
  import isaPkg::*;
();

  localparam int FetchLimit = 60 * FetchTStates;   // Clocks allowed per fetch
  localparam int LevelLimit = 100;

  logic        clk;
  logic        reset_n;
  logic        wait_n;
  logic        int_n;
  logic        nmi_n;
  logic        busrq_n;
  logic [7:0]  dinst;
  logic [7:0]  di;
  logic [15:0] A;
  logic        m1_n;
  logic        rfsh_n;
  logic        halt_n;
  logic        busak_n;
  logic        intcycle_n;
  logic        IntE;

  logic [7:0]             mem [0:65535];
  integer                 seed = 32'he052_ad74;
  int                     errorCount = 0;
  int                     fetchCount = 0;
  logic [15:0]            lastFetch = '0;
  logic [15:0]            prevFetch = '0;
  logic                   lastIntc = 1'b1;
  logic                   prevIntc = 1'b1;
  logic                   trackOn = 1'b1;    // Reference model drives the fetch check
  logic                   m1Prev = 1'b1;
  logic                   rfshPrev = 1'b1;
  logic [RefreshBits-1:0] rCount = '0;

  tvClkGen u_clkGen (.clk, .reset_n);

  tvCore #(.AddrWidth(16)) u_dut
  (
    .clk, .reset_n, .wait_n, .int_n, .nmi_n, .busrq_n, .dinst, .di, .A,
    .m1_n, .rfsh_n, .halt_n, .busak_n, .intcycle_n, .IntE
  );

  assign dinst = mem[A];
  assign di    = mem[A];

  // ------------------------------
  // Helpers
  task automatic abortRun();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic timedOut(input string what);
    $display("Timeout while waiting for %s", what);
    abortRun();
  endtask

  task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp)
    begin
      $display("** Error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      errorCount++;
      abortRun();
    end
  endtask

  // Reference model: JP nn jumps, every other opcode is one byte long
  function automatic logic [15:0] nextFetch(input logic [15:0] addr);
    logic [7:0] op;
    op = mem[addr];
    if (op == OpJp)
      return {mem[addr + 16'd2], mem[addr + 16'd1]};
    else
      return addr + 16'd1;
  endfunction

  // Filler never holds a kept opcode other than NOP
  function automatic logic [7:0] fillByte(input logic [15:0] addr);
    logic [7:0] b;
    b = addr[7:0] ^ addr[15:8] ^ 8'h5A;
    if (b == OpHalt || b == OpDi || b == OpEi || b == OpJp)
      b = OpNop;
    return b;
  endfunction

  function automatic logic outputByName(input string name);
    if (name == "halt_n")
      return halt_n;
    else if (name == "busak_n")
      return busak_n;
    else
      return IntE;
  endfunction

  task automatic placeJp(input logic [15:0] at, input logic [15:0] target);
    mem[at]          = OpJp;
    mem[at + 16'd1]  = target[7:0];
    mem[at + 16'd2]  = target[15:8];
  endtask

  task automatic loadProgram();
    int a;
    for (a = 0; a < 65536; a++)
      mem[a] = fillByte(16'(a));
    placeJp(16'h0002, 16'h0100);  // Two filler bytes first
    placeJp(16'h0101, 16'h2345);
    placeJp(16'h23E5, 16'h4000);  // After 160 filler fetches, R has wrapped
    mem[16'h4000] = OpHalt;
    mem[16'h0066] = OpEi;         // NMI handler
    mem[16'h0038] = OpEi;         // IM1 handler
    mem[16'h0039] = OpDi;         // Masks INT again while int_n is still low
    placeJp(16'h003B, 16'h5000);
  endtask

  task automatic waitFetches(input int count);
    int start;
    int guard;
    start = fetchCount;
    guard = 0;
    while (fetchCount < start + count)
    begin
      @(posedge clk);
      guard++;
      if (guard > count * FetchLimit)
        timedOut("instruction fetches");
    end
  endtask

  task automatic waitFetchAt(input logic [15:0] target, input int limit);
    int start;
    int guard;
    start = fetchCount;
    guard = 0;
    while (!(fetchCount > start && lastFetch == target))
    begin
      @(posedge clk);
      guard++;
      if (guard > limit)
        timedOut($sformatf("a fetch at 0x%h", target));
    end
  endtask

  task automatic waitLevel(input string name, input logic level);
    int guard;
    guard = 0;
    while (outputByName(name) !== level)
    begin
      @(posedge clk);
      guard++;
      if (guard > LevelLimit)
        timedOut($sformatf("%s to become %b", name, level));
    end
  endtask

  // ------------------------------
  // Monitors
  always @(posedge clk)
  begin
    wait_n <= (($random(seed) & 3) != 0);   // About one clock in four stretches T2
  end

  // A fetch starts where m1_n falls
  always @(negedge clk)
  begin
    if (reset_n && m1Prev && !m1_n)
    begin
      if (fetchCount == 0)
        check("A", A, 16'h0000);
      else if (trackOn)
      begin
        check("A", A, nextFetch(lastFetch));
        check("intcycle_n", intcycle_n, 1'b1);
      end
      check("busak_n", busak_n, 1'b1);     // No fetch while the bus is granted
      prevFetch = lastFetch;
      prevIntc  = lastIntc;
      lastFetch = A;
      lastIntc  = intcycle_n;
      fetchCount++;
    end
    m1Prev = m1_n;
  end

  // Refresh address is {I,R} with I at zero
  always @(negedge clk)
  begin
    if (reset_n)
    begin
      if (!rfsh_n)
        check("A (refresh)", A, 16'(rCount));
      else if (!rfshPrev)
        rCount = rCount + 1'b1;            // Wraps at 128
    end
    rfshPrev = rfsh_n;
  end

  // ------------------------------
  // Stimulus
  initial
  begin : stimulus
    int guard;
    int startCount;
    wait_n  = 1'b1;
    int_n   = 1'b1;
    nmi_n   = 1'b1;
    busrq_n = 1'b1;
    loadProgram();

    // Reset levels, also on the clock right after release
    guard = 0;
    do
    begin
      @(negedge clk);
      check("m1_n", m1_n, 1'b1);
      check("rfsh_n", rfsh_n, 1'b1);
      check("halt_n", halt_n, 1'b1);
      check("busak_n", busak_n, 1'b1);
      check("intcycle_n", intcycle_n, 1'b1);
      check("IntE", IntE, 1'b0);
      check("A", A, 16'h0000);
      guard++;
      if (guard > 20)
        timedOut("reset release");
    end
    while (reset_n !== 1'b1);

    // JP/NOP flow and refresh run under the monitors
    waitFetchAt(16'h4000, 40 * FetchLimit);
    trackOn = 1'b0;

    // HALT, then NMI
    waitLevel("halt_n", 1'b0);
    waitFetches(2);
    check("A (halted)", lastFetch, 16'h4001);
    check("A (halted)", prevFetch, 16'h4001);
    nmi_n <= 1'b0;
    repeat (3) @(posedge clk);
    nmi_n <= 1'b1;
    waitLevel("halt_n", 1'b1);
    waitFetchAt(NmiVector, 4 * FetchLimit);
    check("A (NMI cycle)", prevFetch, 16'h4001);

    // EI, one instruction, then IM1 acceptance
    int_n <= 1'b0;
    waitLevel("IntE", 1'b1);
    waitFetchAt(IntVector, 6 * FetchLimit);
    check("A (INT cycle)", prevFetch, NmiVector + 16'd2);
    check("intcycle_n", prevIntc, 1'b0);
    check("intcycle_n", lastIntc, 1'b1);
    check("IntE", IntE, 1'b0);
    trackOn = 1'b1;               // int_n stays low, no further INT cycle

    // Bus request and grant
    waitFetches(5);
    busrq_n <= 1'b0;
    waitLevel("busak_n", 1'b0);
    startCount = fetchCount;
    repeat (12)
    begin
      @(posedge clk);
      check("busak_n", busak_n, 1'b0);
    end
    check("fetch count", 16'(fetchCount), 16'(startCount));
    busrq_n <= 1'b1;
    waitLevel("busak_n", 1'b1);
    waitFetches(20);

    if (errorCount == 0)
    begin
      $display("all tests passed");
      $finish;
    end
    else
    begin
      abortRun();
    end
  end

endmodule

`default_nettype wire

// ==== sim.f ====
src/cycPkg.sv
src/isaPkg.sv
src/tvDecode.sv
src/tvIntCtrl.sv
src/tvSequencer.sv
src/tvAddrUnit.sv
src/tvCore.sv
test/tvClkGen.sv
test/tvCoreTb.sv

// ==== Bender.yml ====
package:
  name: tv_cycle_core

sources:
  - files:
      - src/cycPkg.sv
      - src/isaPkg.sv
      - src/tvDecode.sv
      - src/tvIntCtrl.sv
      - src/tvSequencer.sv
      - src/tvAddrUnit.sv
      - src/tvCore.sv
  - target: test
    files:
      - test/tvClkGen.sv
      - test/tvCoreTb.sv
